// ==== rtl/debugLoader.sv ====
module debugLoader #(
	parameter int addrWidth = 8
) (
	input  logic                     clk,
	input  logic                     nrst,
	input  logic                     dbgLoad,	// one-cycle load strobe
	input  frontendPkg::instrWord_t  dbgAddr,
	input  frontendPkg::instrWord_t  dbgInstr,

	memPortIf.requester              loadPort
);

	logic                     pending;	// a write is waiting for the port
	logic [addrWidth-1:0]     addrReg;
	frontendPkg::instrWord_t  wordReg;
	logic                     writeDone;

	assign writeDone = pending & loadPort.grant;

	// payload capture, a new strobe overwrites a waiting one
	always_ff @(posedge clk)
	begin
		if (dbgLoad)
		begin
			addrReg <= dbgAddr[addrWidth-1:0];
			wordReg <= dbgInstr;
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pending <= 1'b0;
		end
		else if (dbgLoad)
		begin
			pending <= 1'b1;
		end
		else if (writeDone)
		begin
			pending <= 1'b0;
		end
	end

	assign loadPort.req   = pending;
	assign loadPort.we    = pending;	// loader never reads
	assign loadPort.addr  = addrReg;
	assign loadPort.wdata = wordReg;

endmodule

// ==== rtl/frontendPkg.sv ====
package frontendPkg;

	// one instruction word, also used for pc and load addresses
	typedef logic [31:0] instrWord_t;

	// next-pc select, driven by the later stages
	typedef enum logic [1:0]
	{
		pcSeq    = 2'd0,	// pc plus one
		pcZero   = 2'd1,	// restart at reset vector
		pcTarget = 2'd2,	// jump to target
		pcHold   = 2'd3		// keep current pc
	} pcSel_t;

	// pc after reset and on pcZero
	localparam instrWord_t resetVector = 32'h0000_0000;

endpackage

// ==== rtl/frontendTop.sv ====
module frontendTop #(
	parameter int addrWidth = 8
) (
	input  logic                     clk,
	input  logic                     nrst,

	// pipeline control
	input  logic                     stall,
	input  frontendPkg::pcSel_t      pcSel,
	input  frontendPkg::instrWord_t  target,

	// program load
	input  logic                     dbgLoad,
	input  frontendPkg::instrWord_t  dbgAddr,
	input  frontendPkg::instrWord_t  dbgInstr,

	// towards decode
	output frontendPkg::instrWord_t  pc2,
	output frontendPkg::instrWord_t  instr2,
	output logic                     instrValid
);

	// single memory port after arbitration
	logic                     memEn;
	logic                     memWe;
	logic [addrWidth-1:0]     memAddr;
	frontendPkg::instrWord_t  memWdata;
	frontendPkg::instrWord_t  memRdata;

	memPortIf #(.addrWidth(addrWidth)) loadPort ();
	memPortIf #(.addrWidth(addrWidth)) fetchPort ();

	debugLoader #(
		.addrWidth (addrWidth)
	) loader (
		.clk      (clk),
		.nrst     (nrst),
		.dbgLoad  (dbgLoad),
		.dbgAddr  (dbgAddr),
		.dbgInstr (dbgInstr),
		.loadPort (loadPort.requester)
	);

	pcGen #(
		.addrWidth (addrWidth)
	) fetch (
		.clk        (clk),
		.nrst       (nrst),
		.stall      (stall),
		.pcSel      (pcSel),
		.target     (target),
		.fetchPort  (fetchPort.requester),
		.pc2        (pc2),
		.instr2     (instr2),
		.instrValid (instrValid)
	);

	memArbiter #(
		.addrWidth (addrWidth)
	) arb (
		.loadPort  (loadPort.arbiter),
		.fetchPort (fetchPort.arbiter),
		.memEn     (memEn),
		.memWe     (memWe),
		.memAddr   (memAddr),
		.memWdata  (memWdata),
		.memRdata  (memRdata)
	);

	instrMem #(
		.addrWidth (addrWidth)
	) imem (
		.clk   (clk),
		.en    (memEn),
		.we    (memWe),
		.addr  (memAddr),
		.wdata (memWdata),
		.rdata (memRdata)
	);

endmodule

// ==== rtl/instrMem.sv ====
module instrMem #(
	parameter int addrWidth = 8
) (
	input  logic                     clk,
	input  logic                     en,
	input  logic                     we,
	input  logic [addrWidth-1:0]     addr,
	input  frontendPkg::instrWord_t  wdata,
	output frontendPkg::instrWord_t  rdata
);

	localparam int depth = 1 << addrWidth;

	// program storage, filled by the debug loader
	frontendPkg::instrWord_t mem [0:depth-1];

	// registered read data, zero at power up
	frontendPkg::instrWord_t readReg = '0;

	logic doWrite;
	logic doRead;

	assign doWrite = en & we;
	assign doRead  = en & ~we;

	// write side
	always_ff @(posedge clk)
	begin
		if (doWrite)
		begin
			mem[addr] <= wdata;
		end
	end

	// registered read, holds while the port is idle or writing
	always_ff @(posedge clk)
	begin
		if (doRead)
		begin
			readReg <= mem[addr];
		end
	end

	assign rdata = readReg;

endmodule

// ==== rtl/memArbiter.sv ====
module memArbiter #(
	parameter int addrWidth = 8
) (
	memPortIf.arbiter                loadPort,	// high priority
	memPortIf.arbiter                fetchPort,	// low priority

	output logic                     memEn,
	output logic                     memWe,
	output logic [addrWidth-1:0]     memAddr,
	output frontendPkg::instrWord_t  memWdata,
	input  frontendPkg::instrWord_t  memRdata
);

	logic loadWins;
	logic fetchWins;

	// fixed priority, loader first
	assign loadWins  = loadPort.req;
	assign fetchWins = fetchPort.req & ~loadPort.req;

	// grant only ever follows a request
	assign loadPort.grant  = loadWins;
	assign fetchPort.grant = fetchWins;

	// steer the winning request onto the memory
	always_comb
	begin
		memEn    = 1'b0;
		memWe    = 1'b0;
		memAddr  = '0;
		memWdata = '0;

		if (loadWins)
		begin
			memEn    = 1'b1;
			memWe    = loadPort.we;
			memAddr  = loadPort.addr;
			memWdata = loadPort.wdata;
		end
		else if (fetchWins)
		begin
			memEn    = 1'b1;
			memWe    = fetchPort.we;
			memAddr  = fetchPort.addr;
			memWdata = fetchPort.wdata;
		end
	end

	// read data goes back to both, only fetch uses it
	assign loadPort.rdata  = memRdata;
	assign fetchPort.rdata = memRdata;

endmodule

// ==== rtl/memPortIf.sv ====
interface memPortIf #(
	parameter int addrWidth = 8
) ();

	logic                       req;	// requester asks for the port
	logic                       we;		// request is a write
	logic [addrWidth-1:0]       addr;
	frontendPkg::instrWord_t    wdata;
	logic                       grant;	// request accepted this cycle
	frontendPkg::instrWord_t    rdata;	// valid one cycle after a granted read

	// block that asks for memory access
	modport requester
	(
		output req,
		output we,
		output addr,
		output wdata,
		input  grant,
		input  rdata
	);

	// arbiter side
	modport arbiter
	(
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output grant,
		output rdata
	);

endinterface

// ==== rtl/pcGen.sv ====
module pcGen #(
	parameter int addrWidth = 8
) (
	input  logic                     clk,
	input  logic                     nrst,
	input  logic                     stall,
	input  frontendPkg::pcSel_t      pcSel,
	input  frontendPkg::instrWord_t  target,

	memPortIf.requester              fetchPort,

	output frontendPkg::instrWord_t  pc2,
	output frontendPkg::instrWord_t  instr2,
	output logic                     instrValid
);

	frontendPkg::instrWord_t pcReg;		// pc being fetched
	frontendPkg::instrWord_t pc2Reg;	// pc of the word now on rdata
	frontendPkg::instrWord_t npc;		// next pc
	frontendPkg::instrWord_t pcInc;

	logic fetchReq;
	logic fetchDone;	// read granted this cycle
	logic validReg;

	assign pcInc = pcReg + 32'd1;

	// next pc select
	always_comb
	begin
		npc = pcInc;
		unique case (pcSel)
			frontendPkg::pcSeq:
			begin
				npc = pcInc;
			end
			frontendPkg::pcZero:
			begin
				npc = frontendPkg::resetVector;
			end
			frontendPkg::pcTarget:
			begin
				npc = target;
			end
			frontendPkg::pcHold:
			begin
				npc = pcReg;
			end
		endcase
	end

	// read request whenever the pipe is free
	assign fetchReq  = ~stall;
	assign fetchDone = fetchReq & fetchPort.grant;

	assign fetchPort.req   = fetchReq;
	assign fetchPort.we    = 1'b0;	// fetch only reads
	assign fetchPort.addr  = pcReg[addrWidth-1:0];
	assign fetchPort.wdata = '0;

	// pc pipe, moves only on a performed fetch
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pcReg  <= frontendPkg::resetVector;
			pc2Reg <= frontendPkg::resetVector;
		end
		else if (fetchDone)
		begin
			pcReg  <= npc;
			pc2Reg <= pcReg;
		end
	end

	// word from memory lines up with pc2 one cycle later
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			validReg <= 1'b0;
		end
		else
		begin
			validReg <= fetchDone;
		end
	end

	assign pc2        = pc2Reg;
	assign instr2     = fetchPort.rdata;	// memory holds it until the next read
	assign instrValid = validReg;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module frontendTb -o frontendSim

./obj_dir/frontendSim | tee sim.log

if grep -q "Regression passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== verif/frontendTb.sv ====
module frontendTb;

	localparam int addrWidth = 8;

	logic                     clk;
	logic                     nrst;
	logic                     stall;
	frontendPkg::pcSel_t      pcSel;
	frontendPkg::instrWord_t  target;
	logic                     dbgLoad;
	frontendPkg::instrWord_t  dbgAddr;
	frontendPkg::instrWord_t  dbgInstr;
	frontendPkg::instrWord_t  pc2;
	frontendPkg::instrWord_t  instr2;
	logic                     instrValid;

	int seed = 56;
	int errCount = 0;
	int timeoutCount = 0;
	int fetchHits = 0;
	int stallHits = 0;
	int loadHits = 0;
	logic [3:0] selSeen = '0;	// one bit per select checked

	// reference memory and the expected state of the pipe
	frontendPkg::instrWord_t  refMem [0:(1<<addrWidth)-1];
	frontendPkg::instrWord_t  refWord;
	logic [addrWidth-1:0]     pendAddr;
	frontendPkg::instrWord_t  pendWord;
	logic                     modelPending;
	logic                     modelValid;
	logic                     fetchNow;
	frontendPkg::instrWord_t  modelPc;	// pc the next fetch reads
	frontendPkg::instrWord_t  pcNew;	// pc of the latest fetch
	frontendPkg::instrWord_t  pcOld;	// pc of the fetch before it
	frontendPkg::pcSel_t      selNew;
	frontendPkg::pcSel_t      selOld;
	frontendPkg::instrWord_t  tgtNew;
	frontendPkg::instrWord_t  tgtOld;
	logic                     newOk;
	logic                     oldOk;

	tbClock clkGen (
		.clk  (clk),
		.nrst (nrst)
	);

	frontendTop #(
		.addrWidth (addrWidth)
	) dut (
		.clk        (clk),
		.nrst       (nrst),
		.stall      (stall),
		.pcSel      (pcSel),
		.target     (target),
		.dbgLoad    (dbgLoad),
		.dbgAddr    (dbgAddr),
		.dbgInstr   (dbgInstr),
		.pc2        (pc2),
		.instr2     (instr2),
		.instrValid (instrValid)
	);

	// next pc as the select encoding defines it
	function automatic frontendPkg::instrWord_t nextPc(
		input frontendPkg::instrWord_t pc,
		input frontendPkg::pcSel_t     sel,
		input frontendPkg::instrWord_t tgt
	);
		case (sel)
			frontendPkg::pcZero:   return frontendPkg::resetVector;
			frontendPkg::pcTarget: return tgt;
			frontendPkg::pcHold:   return pc;
			default:               return pc + 32'd1;
		endcase
	endfunction

	// loader always wins the port, so a strobe is written at the next edge
	assign fetchNow = !stall && !modelPending;
	assign refWord  = refMem[pc2[addrWidth-1:0]];

	always @(posedge clk)
	begin
		if (modelPending)
		begin
			refMem[pendAddr] <= pendWord;
		end
		if (dbgLoad)
		begin
			pendAddr <= dbgAddr[addrWidth-1:0];
			pendWord <= dbgInstr;
		end
	end

	always @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			modelPending <= 1'b0;
			modelValid   <= 1'b0;
			modelPc      <= frontendPkg::resetVector;
			pcNew        <= '0;
			pcOld        <= '0;
			selNew       <= frontendPkg::pcSeq;
			selOld       <= frontendPkg::pcSeq;
			tgtNew       <= '0;
			tgtOld       <= '0;
			newOk        <= 1'b0;
			oldOk        <= 1'b0;
		end
		else
		begin
			modelPending <= dbgLoad;
			modelValid   <= fetchNow;
			if (fetchNow)
			begin
				modelPc <= nextPc(modelPc, pcSel, target);
				pcNew   <= modelPc;
				selNew  <= pcSel;
				tgtNew  <= target;
				newOk   <= 1'b1;
				pcOld   <= pcNew;
				selOld  <= selNew;
				tgtOld  <= tgtNew;
				oldOk   <= newOk;
			end
		end
	end

	// how often the stimulus reached each check
	always @(posedge clk)
	begin
		if (nrst)
		begin
			if (modelValid)
			begin
				fetchHits++;
			end
			if (stall && modelValid)	// stall right after a performed fetch
			begin
				stallHits++;
			end
			if (modelPending && !stall)	// write takes the port from a running fetch
			begin
				loadHits++;
			end
			if (modelValid && oldOk)
			begin
				selSeen[selOld] = 1'b1;
			end
		end
	end

	task automatic flagError(input string msg);
		errCount++;
		$display("ERROR at time %0t: %s", $time, msg);
	endtask

	resetValues: assert property (@(posedge clk) !nrst |-> (!instrValid && pc2 == '0))
		else flagError($sformatf("in reset instrValid=%0b pc2=%0h", instrValid, pc2));

	afterReset: assert property (@(posedge clk)
		(nrst && !$past(nrst)) |-> (!instrValid && pc2 == '0))
		else flagError("pipe not empty on the first cycle after reset");

	validFlag: assert property (@(posedge clk) disable iff (!nrst) instrValid == modelValid)
		else flagError($sformatf("instrValid=%0b, expected %0b", instrValid, modelValid));

	dataMatch: assert property (@(posedge clk) disable iff (!nrst)
		instrValid |-> instr2 == refWord)
		else flagError($sformatf("instr2=%0h at pc2=%0h, expected %0h", instr2, pc2, refWord));

	pcMatch: assert property (@(posedge clk) disable iff (!nrst) instrValid |-> pc2 == pcNew)
		else flagError($sformatf("pc2=%0h, expected %0h", pc2, pcNew));

	seqStep: assert property (@(posedge clk) disable iff (!nrst)
		(instrValid && oldOk && selOld == frontendPkg::pcSeq) |-> pc2 == pcOld + 32'd1)
		else flagError($sformatf("sequential pc2=%0h after %0h", pc2, pcOld));

	targetStep: assert property (@(posedge clk) disable iff (!nrst)
		(instrValid && oldOk && selOld == frontendPkg::pcTarget) |-> pc2 == tgtOld)
		else flagError($sformatf("jump gave pc2=%0h, target %0h", pc2, tgtOld));

	zeroStep: assert property (@(posedge clk) disable iff (!nrst)
		(instrValid && oldOk && selOld == frontendPkg::pcZero) |-> pc2 == '0)
		else flagError($sformatf("restart gave pc2=%0h", pc2));

	holdStep: assert property (@(posedge clk) disable iff (!nrst)
		(instrValid && oldOk && selOld == frontendPkg::pcHold) |-> pc2 == pcOld)
		else flagError($sformatf("hold gave pc2=%0h, previous %0h", pc2, pcOld));

	stallHolds: assert property (@(posedge clk) disable iff (!nrst)
		($past(stall) && $past(nrst)) |-> (!instrValid && $stable(pc2) && $stable(instr2)))
		else flagError("outputs moved in the cycle after a stall");

	loadBlocks: assert property (@(posedge clk) disable iff (!nrst)
		$past(modelPending) |-> !instrValid)
		else flagError("fetch completed while the loader held the port");

	task automatic reportAndFinish();
		bit reached;
		reached = fetchHits > 0 && stallHits > 0 && loadHits > 0 && selSeen == 4'b1111;
		if (!reached)
		begin
			$display("stimulus did not reach every check");
		end
		$display("fetches %0d, stalls after a fetch %0d, loads during fetch %0d, timeouts %0d, errors %0d",
			fetchHits, stallHits, loadHits, timeoutCount, errCount);
		if (reached && errCount == 0 && timeoutCount == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	endtask

	task automatic abortOnTimeout(input string what);
		timeoutCount++;
		$display("timeout: %s", what);
		reportAndFinish();
	endtask

	task automatic waitForReset(input int limit);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!nrst && cycles < limit);
		if (!nrst)
		begin
			abortOnTimeout("reset was never released");
		end
	endtask

	// returns at the falling edge where pc2 shows the address
	task automatic waitForFetchOf(input frontendPkg::instrWord_t addr, input int limit);
		int cycles;
		bit seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < limit)
		begin
			@(negedge clk);
			cycles++;
			if (instrValid && pc2 == addr)
			begin
				seen = 1'b1;
			end
		end
		if (!seen)
		begin
			abortOnTimeout($sformatf("no fetch of address %0d in %0d cycles", addr, limit));
		end
	endtask

	task automatic strobeLoad(
		input frontendPkg::instrWord_t addr,
		input frontendPkg::instrWord_t word
	);
		@(posedge clk);
		dbgLoad  <= 1'b1;
		dbgAddr  <= addr;
		dbgInstr <= word;
	endtask

	initial
	begin
		logic [31:0] rnd;

		stall    = 1'b1;	// no fetch until the program is in
		pcSel    = frontendPkg::pcSeq;
		target   = '0;
		dbgLoad  = 1'b0;
		dbgAddr  = '0;
		dbgInstr = '0;

		waitForReset(40);

		// program load, one strobe per cycle
		for (int i = 0; i < 32; i++)
		begin
			strobeLoad(i, $random(seed));
		end
		@(posedge clk);
		dbgLoad <= 1'b0;

		@(posedge clk);
		stall <= 1'b0;
		waitForFetchOf(20, 60);

		// jump, hold, restart, then two steps; pc stays inside the program
		for (int i = 0; i < 8; i++)
		begin
			@(posedge clk);
			pcSel  <= frontendPkg::pcTarget;
			target <= $random(seed) & 32'd31;
			@(posedge clk);
			pcSel <= frontendPkg::pcHold;
			@(posedge clk);
			pcSel <= frontendPkg::pcZero;
			repeat (2)
			begin
				@(posedge clk);
				pcSel <= frontendPkg::pcSeq;
			end
		end

		// random stalls, wrap to zero before leaving the program
		for (int i = 0; i < 40; i++)
		begin
			@(posedge clk);
			rnd = $random(seed);
			stall <= rnd[0];
			pcSel <= (modelPc >= 32'd28) ? frontendPkg::pcZero : frontendPkg::pcSeq;
		end
		@(posedge clk);
		stall <= 1'b0;

		// overwrite a word ahead of the fetch, then run into it
		for (int k = 0; k < 4; k++)
		begin
			@(posedge clk);
			pcSel <= frontendPkg::pcZero;
			@(posedge clk);
			pcSel <= frontendPkg::pcSeq;
			strobeLoad(8 + 5 * k, $random(seed));
			@(posedge clk);
			dbgLoad <= 1'b0;
			waitForFetchOf(8 + 5 * k, 40);
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		reportAndFinish();
	end

endmodule

// ==== verif/tbClock.sv ====
module tbClock #(
	parameter int halfPeriod  = 5,
	parameter int resetCycles = 16
) (
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial
	begin
		nrst = 1'b1;
		#1 nrst = 1'b0;	// real falling edge, async reset fires before the first clock
		repeat (resetCycles) @(posedge clk);
		nrst <= 1'b1;
	end

endmodule

// ==== vlog.f ====
rtl/frontendPkg.sv
rtl/memPortIf.sv
rtl/instrMem.sv
rtl/memArbiter.sv
rtl/pcGen.sv
rtl/debugLoader.sv
rtl/frontendTop.sv
verif/tbClock.sv
verif/frontendTb.sv
